//--- common/clint_mem_pkg.sv
package clint_mem_pkg;

   // ******************************************************************
   // widths of the memory port
   // ******************************************************************

   localparam int paddr_width   = 40;
   localparam int dword_width   = 64;
   localparam int payload_width = 8;

   // bytes in one dword and the width of a byte offset inside it
   localparam int dword_bytes  = dword_width / 8;
   localparam int offset_width = $clog2(dword_bytes);

   // ******************************************************************
   // message encodings
   // ******************************************************************

   typedef enum logic [1:0] {
      e_mem_rd    = 2'b00,
      e_mem_uc_rd = 2'b01,
      e_mem_uc_wr = 2'b10,
      e_mem_wb    = 2'b11
   } mem_msg_type_e;

   // access is 2^size bytes
   typedef enum logic [1:0] {
      e_size_1 = 2'b00,
      e_size_2 = 2'b01,
      e_size_4 = 2'b10,
      e_size_8 = 2'b11
   } mem_size_e;

   // one command or response on the port
   typedef struct packed {
      mem_msg_type_e              msg_type;
      logic [paddr_width-1:0]     addr;
      mem_size_e                  size;
      // opaque, handed back untouched
      logic [payload_width-1:0]   payload;
      logic [dword_width-1:0]     data;
   } mem_msg_s;

endpackage

//--- common/clint_map_pkg.sv
package clint_map_pkg;

   // ******************************************************************
   // address map, dword aligned
   // ******************************************************************

   localparam logic [clint_mem_pkg::paddr_width-1:0] msip_addr     = 40'h00_0200_0000;
   localparam logic [clint_mem_pkg::paddr_width-1:0] mtimecmp_addr = 40'h00_0200_4000;
   localparam logic [clint_mem_pkg::paddr_width-1:0] mtime_addr    = 40'h00_0200_bff8;
   localparam logic [clint_mem_pkg::paddr_width-1:0] meip_addr     = 40'h00_0c00_0000;

   // which register a command touches
   typedef enum logic [2:0] {
      e_reg_none     = 3'd0,
      e_reg_msip     = 3'd1,
      e_reg_mtimecmp = 3'd2,
      e_reg_mtime    = 3'd3,
      e_reg_meip     = 3'd4
   } clint_reg_e;

   // decoded request handed to the register file and formatter
   typedef struct packed {
      clint_reg_e                                 sel;
      logic                                       wr;
      // byte offset inside the dword
      logic [clint_mem_pkg::offset_width-1:0]     offset;
      logic [clint_mem_pkg::dword_bytes-1:0]      byte_en;
      // right-justified write data
      logic [clint_mem_pkg::dword_width-1:0]      wdata;
   } clint_req_s;

endpackage

//--- hw/clint_cmd_decode.sv
module clint_cmd_decode (
   input  clint_mem_pkg::mem_msg_s   mem_cmd_i,
   input  logic                      mem_cmd_v_i,
   input  logic                      mem_resp_ready_i,
   output logic                      mem_cmd_yumi_o,
   output logic                      req_v_o,
   output clint_map_pkg::clint_req_s req_o
);

   import clint_mem_pkg::*;
   import clint_map_pkg::*;

   logic                                 accept;
   logic [paddr_width-offset_width-1:0]  dword_addr;
   logic [dword_bytes-1:0]               size_mask;

   // the response goes out in the same cycle, so ready gates acceptance
   assign accept         = mem_cmd_v_i & mem_resp_ready_i;
   assign mem_cmd_yumi_o = accept;
   assign req_v_o        = accept;

   assign dword_addr = mem_cmd_i.addr[paddr_width-1:offset_width];

   // bytes covered by the access before shifting to the offset
   always_comb begin
      case (mem_cmd_i.size)
         e_size_1: size_mask = 8'h01;
         e_size_2: size_mask = 8'h03;
         e_size_4: size_mask = 8'h0f;
         default:  size_mask = 8'hff;
      endcase
   end

   always_comb begin
      req_o = '0;

      case (dword_addr)
         msip_addr[paddr_width-1:offset_width]:     req_o.sel = e_reg_msip;
         mtimecmp_addr[paddr_width-1:offset_width]: req_o.sel = e_reg_mtimecmp;
         mtime_addr[paddr_width-1:offset_width]:    req_o.sel = e_reg_mtime;
         meip_addr[paddr_width-1:offset_width]:     req_o.sel = e_reg_meip;
         default:                                   req_o.sel = e_reg_none;
      endcase

      req_o.wr      = mem_cmd_i.msg_type inside {e_mem_uc_wr, e_mem_wb};
      req_o.offset  = mem_cmd_i.addr[offset_width-1:0];
      // lanes past the top byte fall off, misaligned commands are not supported
      req_o.byte_en = size_mask << mem_cmd_i.addr[offset_width-1:0];
      req_o.wdata   = mem_cmd_i.data;
   end

endmodule

//--- clint_regs/clint_reg_file.sv
module clint_reg_file (
   input  logic                                    clk_i,
   input  logic                                    arst_n_i,
   input  logic                                    req_v_i,
   input  clint_map_pkg::clint_req_s               req_i,
   output logic [clint_mem_pkg::dword_width-1:0]   rdata_o,
   output logic                                    software_irq_o,
   output logic                                    timer_irq_o,
   output logic                                    external_irq_o
);

   import clint_mem_pkg::*;
   import clint_map_pkg::*;

   logic [dword_width-1:0] mtime_r;
   logic [dword_width-1:0] mtimecmp_r;
   logic [dword_width-1:0] mtimecmp_n;
   logic [dword_width-1:0] wdata_sh;
   logic                   msip_r;
   logic                   meip_r;

   logic                   wr_v;
   logic                   mtimecmp_we;
   logic                   msip_we;
   logic                   meip_we;

   // ******************************************************************
   // write enables
   // ******************************************************************

   assign wr_v        = req_v_i & req_i.wr;
   assign mtimecmp_we = wr_v & (req_i.sel == e_reg_mtimecmp);
   // single-bit registers only take a write that covers byte 0
   assign msip_we     = wr_v & (req_i.sel == e_reg_msip) & req_i.byte_en[0];
   assign meip_we     = wr_v & (req_i.sel == e_reg_meip) & req_i.byte_en[0];

   // move write data up to its byte lanes, then merge the enabled ones
   always_comb begin
      wdata_sh   = req_i.wdata << {req_i.offset, 3'b000};
      mtimecmp_n = mtimecmp_r;
      for (int i = 0; i < dword_bytes; i++) begin
         if (req_i.byte_en[i]) begin
            mtimecmp_n[8*i +: 8] = wdata_sh[8*i +: 8];
         end
      end
   end

   // ******************************************************************
   // registers
   // ******************************************************************

   // counts core clocks, no real-time source
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         mtime_r <= '0;
      end else begin
         mtime_r <= mtime_r + 64'd1;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         mtimecmp_r <= '1;
      end else if (mtimecmp_we) begin
         mtimecmp_r <= mtimecmp_n;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         msip_r <= 1'b0;
         meip_r <= 1'b0;
      end else begin
         if (msip_we) begin
            msip_r <= req_i.wdata[0];
         end
         if (meip_we) begin
            meip_r <= req_i.wdata[0];
         end
      end
   end

   // ******************************************************************
   // read mux and interrupt levels
   // ******************************************************************

   always_comb begin
      case (req_i.sel)
         e_reg_msip:     rdata_o = dword_width'(msip_r);
         e_reg_mtimecmp: rdata_o = mtimecmp_r;
         e_reg_mtime:    rdata_o = mtime_r;
         e_reg_meip:     rdata_o = dword_width'(meip_r);
         default:        rdata_o = '0;
      endcase
   end

   assign timer_irq_o    = (mtime_r >= mtimecmp_r);
   assign software_irq_o = msip_r;
   assign external_irq_o = meip_r;

endmodule

//--- hw/clint_resp_format.sv
module clint_resp_format (
   input  clint_mem_pkg::mem_msg_s                mem_cmd_i,
   input  clint_map_pkg::clint_req_s              req_i,
   input  logic [clint_mem_pkg::dword_width-1:0]  rdata_i,
   output clint_mem_pkg::mem_msg_s                mem_resp_o
);

   import clint_mem_pkg::*;
   import clint_map_pkg::*;

   logic [dword_width-1:0] rdata_sh;
   logic [dword_width-1:0] size_mask;
   logic [dword_width-1:0] resp_data;

   // keep the low 2^size bytes
   always_comb begin
      case (mem_cmd_i.size)
         e_size_1: size_mask = 64'h0000_0000_0000_00ff;
         e_size_2: size_mask = 64'h0000_0000_0000_ffff;
         e_size_4: size_mask = 64'h0000_0000_ffff_ffff;
         default:  size_mask = '1;
      endcase
   end

   // bring the addressed bytes down to bit 0
   assign rdata_sh = rdata_i >> {req_i.offset, 3'b000};

   always_comb begin
      if (req_i.wr) begin
         resp_data = '0;
      end else begin
         resp_data = rdata_sh & size_mask;
      end
   end

   // everything but data is echoed from the command
   always_comb begin
      mem_resp_o = '{
         msg_type: mem_cmd_i.msg_type,
         addr:     mem_cmd_i.addr,
         size:     mem_cmd_i.size,
         payload:  mem_cmd_i.payload,
         data:     resp_data
      };
   end

endmodule

//--- hw/clint_top.sv
module clint_top (
   input  logic                     clk_i,
   input  logic                     arst_n_i,

   input  clint_mem_pkg::mem_msg_s  mem_cmd_i,
   input  logic                     mem_cmd_v_i,
   output logic                     mem_cmd_yumi_o,

   output clint_mem_pkg::mem_msg_s  mem_resp_o,
   output logic                     mem_resp_v_o,
   input  logic                     mem_resp_ready_i,

   // interrupt levels to the hart
   output logic                     software_irq_o,
   output logic                     timer_irq_o,
   output logic                     external_irq_o
);

   import clint_mem_pkg::*;
   import clint_map_pkg::*;

   logic                   req_v;
   clint_req_s             req;
   logic [dword_width-1:0] rdata;

   // ******************************************************************
   // command decode, register file, response build
   // ******************************************************************

   clint_cmd_decode i_decode (
      .mem_cmd_i        (mem_cmd_i),
      .mem_cmd_v_i      (mem_cmd_v_i),
      .mem_resp_ready_i (mem_resp_ready_i),
      .mem_cmd_yumi_o   (mem_cmd_yumi_o),
      .req_v_o          (req_v),
      .req_o            (req)
   );

   clint_reg_file i_regs (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .req_v_i        (req_v),
      .req_i          (req),
      .rdata_o        (rdata),
      .software_irq_o (software_irq_o),
      .timer_irq_o    (timer_irq_o),
      .external_irq_o (external_irq_o)
   );

   clint_resp_format i_format (
      .mem_cmd_i  (mem_cmd_i),
      .req_i      (req),
      .rdata_i    (rdata),
      .mem_resp_o (mem_resp_o)
   );

   // answered in the cycle it is accepted
   assign mem_resp_v_o = req_v;

endmodule

//--- verif/clint_chk.sv
module clint_chk (
   input logic                      clk_i,
   input logic                      arst_n_i,
   input clint_mem_pkg::mem_msg_s   mem_cmd_i,
   input logic                      cmd_v_i,
   input logic                      yumi_i,
   input logic                      resp_v_i,
   input logic                      resp_ready_i,
   input clint_map_pkg::clint_req_s req_i,
   input logic [63:0]               mtime_i,
   input logic [63:0]               mtimecmp_i,
   input logic                      timer_irq_i
);

   timeunit 1ns;
   timeprecision 100ps;

   import clint_mem_pkg::*;
   import clint_map_pkg::*;

   logic        mtimecmp_wr;
   logic [2:0]  align_mask;
   logic [63:0] mtimecmp_exp;

   assign mtimecmp_wr = yumi_i & req_i.wr & (req_i.sel == e_reg_mtimecmp);
   // offset bits that must be zero for the access size
   assign align_mask  = ~(3'b111 << mem_cmd_i.size);

   // mtimecmp after the write where data byte k lands in lane k plus offset
   always_comb begin
      mtimecmp_exp = mtimecmp_i;
      for (int k = 0; k < 8; k++) begin
         if (req_i.byte_en[k] && (k >= int'(req_i.offset))) begin
            mtimecmp_exp[8*k +: 8] = req_i.wdata[8*(k - int'(req_i.offset)) +: 8];
         end
      end
   end

   yumi_needs_handshake: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      yumi_i |-> (cmd_v_i && resp_ready_i))
      else $error("yumi asserted without valid and ready");

   resp_v_follows_yumi: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      resp_v_i == yumi_i)
      else $error("response valid differs from yumi");

   offset_aligned: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      yumi_i |-> ((req_i.offset & align_mask) == 3'd0))
      else $error("accepted command is misaligned");

   // level compare once the new mtimecmp is in place
   timer_irq_level: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      mtimecmp_wr |=> (timer_irq_i == (mtime_i >= $past(mtimecmp_exp))))
      else $error("timer interrupt level does not match mtime and the written mtimecmp");

endmodule

bind clint_top clint_chk i_chk (
   .clk_i        (clk_i),
   .arst_n_i     (arst_n_i),
   .mem_cmd_i    (mem_cmd_i),
   .cmd_v_i      (mem_cmd_v_i),
   .yumi_i       (mem_cmd_yumi_o),
   .resp_v_i     (mem_resp_v_o),
   .resp_ready_i (mem_resp_ready_i),
   .req_i        (req),
   .mtime_i      (i_regs.mtime_r),
   .mtimecmp_i   (i_regs.mtimecmp_r),
   .timer_irq_i  (timer_irq_o)
);

//--- verif/clint_tb.sv
module clint_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import clint_mem_pkg::*;
   import clint_map_pkg::*;

   localparam int num_cmds       = 2000;
   localparam int accept_timeout = 64;
   localparam int reset_cycles   = 10;

   logic     clk;
   logic     arst_n;
   mem_msg_s mem_cmd;
   logic     mem_cmd_v;
   logic     mem_cmd_yumi;
   mem_msg_s mem_resp;
   logic     mem_resp_v;
   logic     mem_resp_ready;
   logic     software_irq;
   logic     timer_irq;
   logic     external_irq;

   logic [31:0] rng_state;

   // reference model of the register state
   logic [63:0] m_mtime;
   logic [63:0] m_mtimecmp;
   logic        m_msip;
   logic        m_meip;

   clint_top i_dut (
      .clk_i            (clk),
      .arst_n_i         (arst_n),
      .mem_cmd_i        (mem_cmd),
      .mem_cmd_v_i      (mem_cmd_v),
      .mem_cmd_yumi_o   (mem_cmd_yumi),
      .mem_resp_o       (mem_resp),
      .mem_resp_v_o     (mem_resp_v),
      .mem_resp_ready_i (mem_resp_ready),
      .software_irq_o   (software_irq),
      .timer_irq_o      (timer_irq),
      .external_irq_o   (external_irq)
   );

   always #50 clk = ~clk;

   // **********************************************************************
   // helpers
   // **********************************************************************

   function automatic logic [31:0] lcg_next();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   function automatic logic is_write(input mem_msg_s cmd);
      return (cmd.msg_type == e_mem_uc_wr) || (cmd.msg_type == e_mem_wb);
   endfunction

   task automatic abort_run();
      $display("Result: FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      assert (got === exp) else begin
         $display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
         abort_run();
      end
   endtask

   // random target, aligned offset, type and data
   task automatic build_command(output mem_msg_s cmd, output clint_reg_e tgt);
      logic [31:0] r;
      logic [31:0] a;
      logic [39:0] base;
      logic [2:0]  off;
      r = lcg_next();
      case (r[31:29])
         3'd0, 3'd1: begin
            tgt  = e_reg_mtimecmp;
            base = mtimecmp_addr;
         end
         3'd2: begin
            tgt  = e_reg_mtime;
            base = mtime_addr;
         end
         3'd3: begin
            tgt  = e_reg_msip;
            base = msip_addr;
         end
         3'd4: begin
            tgt  = e_reg_meip;
            base = meip_addr;
         end
         default: begin
            // a window that holds no register
            tgt  = e_reg_none;
            base = 40'h00_0300_0000 + {21'd0, r[15:0], 3'b000};
         end
      endcase
      off          = (r[24:22] >> r[26:25]) << r[26:25];
      cmd.msg_type = mem_msg_type_e'(r[28:27]);
      cmd.size     = mem_size_e'(r[26:25]);
      cmd.addr     = base | {37'd0, off};
      cmd.payload  = r[7:0];
      a = lcg_next();
      case (a[1:0])
         2'd0:    cmd.data = '0;
         // near the current count, so the timer compare flips now and then
         2'd1:    cmd.data = m_mtime + {58'd0, a[7:2]};
         default: cmd.data = {lcg_next(), a};
      endcase
   endtask

   function automatic logic [63:0] expected_data(input mem_msg_s cmd, input clint_reg_e tgt);
      logic [63:0] full;
      logic [63:0] mask;
      int          nbytes;
      nbytes = 1 << int'(cmd.size);
      case (tgt)
         e_reg_msip:     full = {63'd0, m_msip};
         e_reg_mtimecmp: full = m_mtimecmp;
         e_reg_mtime:    full = m_mtime;
         e_reg_meip:     full = {63'd0, m_meip};
         default:        full = '0;
      endcase
      if (nbytes == 8) begin
         mask = '1;
      end else begin
         mask = (64'd1 << (8 * nbytes)) - 64'd1;
      end
      if (is_write(cmd)) begin
         return '0;
      end
      return (full >> (8 * cmd.addr[2:0])) & mask;
   endfunction

   task automatic apply_write(input mem_msg_s cmd, input clint_reg_e tgt);
      int nbytes;
      int off;
      nbytes = 1 << int'(cmd.size);
      off    = int'(cmd.addr[2:0]);
      if (is_write(cmd)) begin
         case (tgt)
            e_reg_mtimecmp: begin
               for (int k = 0; k < nbytes; k++) begin
                  m_mtimecmp[8*(off+k) +: 8] = cmd.data[8*k +: 8];
               end
            end
            e_reg_msip: begin
               if (off == 0) m_msip = cmd.data[0];
            end
            e_reg_meip: begin
               if (off == 0) m_meip = cmd.data[0];
            end
            default: begin
            end
         endcase
      end
   endtask

   task automatic check_outputs(input mem_msg_s cmd, input clint_reg_e tgt,
                                input logic exp_acc);
      check_value("mem_cmd_yumi_o", 64'(mem_cmd_yumi), 64'(exp_acc));
      check_value("mem_resp_v_o", 64'(mem_resp_v), 64'(exp_acc));
      if (exp_acc) begin
         check_value("mem_resp_o.msg_type", 64'(mem_resp.msg_type), 64'(cmd.msg_type));
         check_value("mem_resp_o.addr", 64'(mem_resp.addr), 64'(cmd.addr));
         check_value("mem_resp_o.size", 64'(mem_resp.size), 64'(cmd.size));
         check_value("mem_resp_o.payload", 64'(mem_resp.payload), 64'(cmd.payload));
         check_value("mem_resp_o.data", mem_resp.data, expected_data(cmd, tgt));
      end
      check_value("timer_irq_o", 64'(timer_irq), 64'(m_mtime >= m_mtimecmp));
      check_value("software_irq_o", 64'(software_irq), 64'(m_msip));
      check_value("external_irq_o", 64'(external_irq), 64'(m_meip));
   endtask

   // entered on a falling edge, leaves on the next one
   task automatic drive_cycle(input mem_msg_s cmd, input clint_reg_e tgt, input logic valid,
                              input logic ready, output logic accepted);
      mem_cmd        = cmd;
      mem_cmd_v      = valid;
      mem_resp_ready = ready;
      accepted       = valid & ready;
      #40;
      check_outputs(cmd, tgt, accepted);
      @(posedge clk);
      if (accepted) apply_write(cmd, tgt);
      m_mtime = m_mtime + 64'd1;
      @(negedge clk);
   endtask

   // **********************************************************************
   // stimulus
   // **********************************************************************

   initial begin
      mem_msg_s    cmd;
      clint_reg_e  tgt;
      logic [31:0] r;
      logic        accepted;
      int          waited;

      rng_state      = 32'h8310;
      clk            = 1'b0;
      arst_n         = 1'b0;
      mem_cmd        = '0;
      mem_cmd_v      = 1'b0;
      mem_resp_ready = 1'b0;
      m_mtime        = '0;
      m_mtimecmp     = '1;
      m_msip         = 1'b0;
      m_meip         = 1'b0;

      for (int c = 0; c < reset_cycles; c++) begin
         @(posedge clk);
      end
      @(negedge clk);
      check_outputs(mem_cmd, e_reg_none, 1'b0);
      arst_n = 1'b1;

      for (int n = 0; n < num_cmds; n++) begin
         r = lcg_next();
         // a cycle that must not be consumed, valid without ready or the reverse
         if (r[31:30] == 2'd0) begin
            build_command(cmd, tgt);
            drive_cycle(cmd, tgt, r[29], ~r[29] & r[28], accepted);
         end
         build_command(cmd, tgt);
         accepted = 1'b0;
         waited   = 0;
         while (!accepted && waited < accept_timeout) begin
            r = lcg_next();
            drive_cycle(cmd, tgt, 1'b1, r[31:30] != 2'd0, accepted);
            waited++;
         end
         assert (accepted) else begin
            $display("timeout: command to address 0x%010h was not accepted within %0d cycles",
                     cmd.addr, accept_timeout);
            abort_run();
         end
      end

      mem_cmd_v = 1'b0;
      $display("Result: PASSED");
      $finish;
   end

endmodule

//--- clint_top.f
common/clint_mem_pkg.sv
common/clint_map_pkg.sv
hw/clint_cmd_decode.sv
clint_regs/clint_reg_file.sv
hw/clint_resp_format.sv
hw/clint_top.sv
verif/clint_chk.sv
verif/clint_tb.sv

//--- run.sh
#!/bin/sh
# build and run the CLINT testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module clint_tb \
   -f clint_top.f \
   -o Vclint_tb

status=0
output=$(./obj_dir/Vclint_tb 2>&1) || status=$?
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx 'Result: PASSED'; then
   exit 0
fi

echo "simulation did not pass (exit status $status)"
exit 1
